/* Bender.yml */
package:
  name: icache

sources:
  - icache_pkg.sv
  - icache_tag_store.sv
  - icache_data_ram.sv
  - icache_replace.sv
  - icache_refill.sv
  - icache_ctrl.sv
  - icache_top.sv
  - target: simulation
    files:
      - tb_icache.sv

/* icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl (
    input  wire                           clk,
    input  wire                           rst_n_i,
    input  wire icache_pkg::fetch_addr_u  fetch_addr_i,
    input  wire                           fetch_req_i,
    input  wire                           core_stall_i,
    input  wire [icache_pkg::TAG_W-1:0]   tag0_i,
    input  wire [icache_pkg::TAG_W-1:0]   tag1_i,
    input  wire                           valid0_i,
    input  wire                           valid1_i,
    input  wire [icache_pkg::LINE_W-1:0]  line0_i,
    input  wire [icache_pkg::LINE_W-1:0]  line1_i,
    input  wire                           refill_done_i,
    output logic                          refill_start_o,
    output logic                          touch_o,
    output logic                          touch_way_o,
    output logic [icache_pkg::INST_W-1:0] fetch_data_o,
    output logic                          fetch_valid_o
);
    import icache_pkg::*;

    logic [2:0]        state_q;
    logic [2:0]        state_d;
    logic              hit0;
    logic              hit1;
    logic              hit_way_q;
    logic [LINE_W-1:0] hit_line;

    // tag compare on the registered read
    assign hit0 = valid0_i && (tag0_i == fetch_addr_i.fields.tag);
    assign hit1 = valid1_i && (tag1_i == fetch_addr_i.fields.tag);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (fetch_req_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            // arrays read at the index during this cycle
            ST_LOOKUP: state_d = ST_COMPARE;
            ST_COMPARE: begin
                if (hit0 || hit1) begin
                    state_d = ST_HIT;
                end else begin
                    state_d = ST_REFILL;
                end
            end
            ST_HIT: begin
                if (!core_stall_i) begin
                    state_d = ST_IDLE;
                end
            end
            ST_REFILL: begin
                // look again, the line is now present
                if (refill_done_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // remember the hitting way for delivery
    always_ff @(posedge clk) begin
        if (state_q == ST_COMPARE) begin
            hit_way_q <= !hit0;
        end
    end

    assign refill_start_o = (state_q == ST_COMPARE) && !hit0 && !hit1;

    assign hit_line     = hit_way_q ? line1_i : line0_i;
    assign fetch_data_o = fetch_addr_i.fields.word_sel ? hit_line[LINE_W-1:INST_W]
                                                       : hit_line[INST_W-1:0];

    // a stalled core keeps the word waiting in hit
    assign fetch_valid_o = (state_q == ST_HIT) && !core_stall_i;
    assign touch_o       = fetch_valid_o;
    assign touch_way_o   = hit_way_q;

endmodule

`default_nettype wire

/* icache_data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_data_ram (
    input  wire                            clk,
    input  wire [icache_pkg::INDEX_W-1:0]  index_i,
    input  wire                            fill_we_i,
    input  wire                            fill_way_i,
    input  wire [icache_pkg::LINE_W-1:0]   fill_line_i,
    output logic [icache_pkg::LINE_W-1:0]  line0_o,
    output logic [icache_pkg::LINE_W-1:0]  line1_o
);
    import icache_pkg::*;

    logic [LINE_W-1:0] way0_mem [NUM_SETS];
    logic [LINE_W-1:0] way1_mem [NUM_SETS];

    // write only the chosen way
    always_ff @(posedge clk) begin
        if (fill_we_i) begin
            if (fill_way_i) begin
                way1_mem[index_i] <= fill_line_i;
            end else begin
                way0_mem[index_i] <= fill_line_i;
            end
        end
    end

    // both ways read every cycle
    always_ff @(posedge clk) begin
        line0_o <= way0_mem[index_i];
        line1_o <= way1_mem[index_i];
    end

endmodule

`default_nettype wire

/* icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // geometry
    localparam int ADDR_W   = 64;
    localparam int INST_W   = 32;
    localparam int LINE_W   = 64;
    localparam int NUM_SETS = 64;
    localparam int INDEX_W  = 6;
    localparam int TAG_W    = 23;
    localparam int AGE_W    = 3;

    // peripheral window, no bursts allowed here
    localparam logic [ADDR_W-1:0] PERIPH_BASE  = 64'h1000_0000;
    localparam logic [ADDR_W-1:0] PERIPH_LIMIT = 64'h1000_0FFF;

    // lookup controller states
    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_LOOKUP  = 3'd1;
    localparam logic [2:0] ST_COMPARE = 3'd2;
    localparam logic [2:0] ST_HIT     = 3'd3;
    localparam logic [2:0] ST_REFILL  = 3'd4;

    // refill sequencer states
    localparam logic [2:0] RF_IDLE   = 3'd0;
    localparam logic [2:0] RF_REQ    = 3'd1;
    localparam logic [2:0] RF_REQ_HI = 3'd2;
    localparam logic [2:0] RF_REQ_LO = 3'd3;
    localparam logic [2:0] RF_WRITE  = 3'd4;
    localparam logic [2:0] RF_DONE   = 3'd5;

    // fetch address, seen whole or split into cache fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [31:0]        upper;
            logic [TAG_W-1:0]   tag;
            logic [INDEX_W-1:0] index;
            logic               word_sel;
            logic [1:0]         byte_off;
        } fields;
    } fetch_addr_u;

endpackage

`default_nettype wire

/* icache_refill.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_refill (
    input  wire                           clk,
    input  wire                           rst_n_i,
    input  wire icache_pkg::fetch_addr_u  fetch_addr_i,
    input  wire                           refill_start_i,
    input  wire                           victim_way_i,
    output logic                          mem_req_o,
    output logic [icache_pkg::ADDR_W-1:0] mem_addr_o,
    input  wire [icache_pkg::LINE_W-1:0]  mem_rdata_i,
    input  wire                           mem_valid_i,
    output logic                          fill_we_o,
    output logic                          fill_way_o,
    output logic [icache_pkg::LINE_W-1:0] fill_line_o,
    output logic                          refill_done_o
);
    import icache_pkg::*;

    logic [2:0]        state_q;
    logic [2:0]        state_d;
    logic              is_periph;
    logic              way_q;
    logic [INST_W-1:0] upper_q;
    logic [LINE_W-1:0] line_q;

    assign is_periph = (fetch_addr_i.raw >= PERIPH_BASE) &&
                       (fetch_addr_i.raw <= PERIPH_LIMIT);

    always_comb begin
        state_d = state_q;
        case (state_q)
            RF_IDLE: begin
                if (refill_start_i) begin
                    state_d = is_periph ? RF_REQ_HI : RF_REQ;
                end
            end
            RF_REQ: begin
                if (mem_valid_i) begin
                    state_d = RF_WRITE;
                end
            end
            // upper word of the pair goes out first
            RF_REQ_HI: begin
                if (mem_valid_i) begin
                    state_d = RF_REQ_LO;
                end
            end
            RF_REQ_LO: begin
                if (mem_valid_i) begin
                    state_d = RF_WRITE;
                end
            end
            RF_WRITE: state_d = RF_DONE;
            default:  state_d = RF_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= RF_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // beat capture and victim latch
    always_ff @(posedge clk) begin
        if (state_q == RF_IDLE && refill_start_i) begin
            way_q <= victim_way_i;
        end
        if (state_q == RF_REQ && mem_valid_i) begin
            line_q <= mem_rdata_i;
        end
        if (state_q == RF_REQ_HI && mem_valid_i) begin
            upper_q <= mem_rdata_i[INST_W-1:0];
        end
        if (state_q == RF_REQ_LO && mem_valid_i) begin
            line_q <= {upper_q, mem_rdata_i[INST_W-1:0]};
        end
    end

    // request level drops with the answering beat
    assign mem_req_o = ((state_q == RF_REQ) || (state_q == RF_REQ_HI) ||
                        (state_q == RF_REQ_LO)) && !mem_valid_i;

    assign mem_addr_o = (state_q == RF_REQ_HI) ? {fetch_addr_i.raw[ADDR_W-1:3], 3'b100}
                                               : {fetch_addr_i.raw[ADDR_W-1:3], 3'b000};

    assign fill_we_o     = (state_q == RF_WRITE);
    assign fill_way_o    = way_q;
    assign fill_line_o   = line_q;
    assign refill_done_o = (state_q == RF_DONE);

endmodule

`default_nettype wire

/* icache_replace.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_replace (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire icache_pkg::fetch_addr_u fetch_addr_i,
    input  wire                          valid0_i,
    input  wire                          valid1_i,
    input  wire                          touch_i,
    input  wire                          touch_way_i,
    input  wire                          fill_we_i,
    input  wire                          fill_way_i,
    output logic                         victim_way_o
);
    import icache_pkg::*;

    logic [AGE_W-1:0]   age0_q [NUM_SETS];
    logic [AGE_W-1:0]   age1_q [NUM_SETS];
    logic [INDEX_W-1:0] idx;

    assign idx = fetch_addr_i.fields.index;

    // saturating step
    function automatic logic [AGE_W-1:0] age_inc(input logic [AGE_W-1:0] age);
        return (age == '1) ? age : age + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                age0_q[s] <= '0;
                age1_q[s] <= '0;
            end
        end else if (touch_i) begin
            // everything ages, then the used way is renewed
            for (int s = 0; s < NUM_SETS; s++) begin
                age0_q[s] <= age_inc(age0_q[s]);
                age1_q[s] <= age_inc(age1_q[s]);
            end
            if (touch_way_i) begin
                age1_q[idx] <= '0;
            end else begin
                age0_q[idx] <= '0;
            end
        end else if (fill_we_i) begin
            if (fill_way_i) begin
                age1_q[idx] <= '0;
            end else begin
                age0_q[idx] <= '0;
            end
        end
    end

    // empty ways first, then the older one, ties go to way 0
    always_comb begin
        if (!valid0_i) begin
            victim_way_o = 1'b0;
        end else if (!valid1_i) begin
            victim_way_o = 1'b1;
        end else if (age0_q[idx] >= age1_q[idx]) begin
            victim_way_o = 1'b0;
        end else begin
            victim_way_o = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* icache_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tag_store (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire icache_pkg::fetch_addr_u fetch_addr_i,
    input  wire                          fill_we_i,
    input  wire                          fill_way_i,
    input  wire                          fence_i,
    output logic [icache_pkg::TAG_W-1:0] tag0_o,
    output logic [icache_pkg::TAG_W-1:0] tag1_o,
    output logic                         valid0_o,
    output logic                         valid1_o
);
    import icache_pkg::*;

    logic [TAG_W-1:0]    tag0_mem [NUM_SETS];
    logic [TAG_W-1:0]    tag1_mem [NUM_SETS];
    logic [NUM_SETS-1:0] valid0_q;
    logic [NUM_SETS-1:0] valid1_q;
    // extra bit marks the end of the sweep
    logic [INDEX_W:0]    sweep_q;
    logic [INDEX_W-1:0]  idx;

    assign idx = fetch_addr_i.fields.index;

    // valid bits and fence sweep, fence wins over a fill
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid0_q <= '0;
            valid1_q <= '0;
            sweep_q  <= '0;
        end else if (fence_i) begin
            if (!sweep_q[INDEX_W]) begin
                valid0_q[sweep_q[INDEX_W-1:0]] <= 1'b0;
                valid1_q[sweep_q[INDEX_W-1:0]] <= 1'b0;
                sweep_q <= sweep_q + 1'b1;
            end
        end else begin
            sweep_q <= '0;
            if (fill_we_i) begin
                if (fill_way_i) begin
                    valid1_q[idx] <= 1'b1;
                end else begin
                    valid0_q[idx] <= 1'b1;
                end
            end
        end
    end

    // tag arrays
    always_ff @(posedge clk) begin
        if (fill_we_i && !fence_i) begin
            if (fill_way_i) begin
                tag1_mem[idx] <= fetch_addr_i.fields.tag;
            end else begin
                tag0_mem[idx] <= fetch_addr_i.fields.tag;
            end
        end
        tag0_o <= tag0_mem[idx];
        tag1_o <= tag1_mem[idx];
    end

    // registered valid read
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid0_o <= 1'b0;
            valid1_o <= 1'b0;
        end else begin
            valid0_o <= valid0_q[idx];
            valid1_o <= valid1_q[idx];
        end
    end

endmodule

`default_nettype wire

/* icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire                           clk,
    input  wire                           rst_n_i,
    input  wire                           fetch_req_i,
    input  wire [icache_pkg::ADDR_W-1:0]  fetch_addr_i,
    input  wire                           core_stall_i,
    input  wire                           fence_i,
    output logic [icache_pkg::INST_W-1:0] fetch_data_o,
    output logic                          fetch_valid_o,
    output logic                          mem_req_o,
    output logic [icache_pkg::ADDR_W-1:0] mem_addr_o,
    input  wire [icache_pkg::LINE_W-1:0]  mem_rdata_i,
    input  wire                           mem_valid_i
);
    import icache_pkg::*;

    fetch_addr_u       fetch_addr;
    logic [TAG_W-1:0]  tag0;
    logic [TAG_W-1:0]  tag1;
    logic              valid0;
    logic              valid1;
    logic [LINE_W-1:0] line0;
    logic [LINE_W-1:0] line1;
    logic              refill_start;
    logic              refill_done;
    logic              victim_way;
    logic              touch;
    logic              touch_way;
    logic              fill_we;
    logic              fill_way;
    logic [LINE_W-1:0] fill_line;

    assign fetch_addr.raw = fetch_addr_i;

    icache_tag_store u_tag_store (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .fetch_addr_i (fetch_addr),
        .fill_we_i    (fill_we),
        .fill_way_i   (fill_way),
        .fence_i      (fence_i),
        .tag0_o       (tag0),
        .tag1_o       (tag1),
        .valid0_o     (valid0),
        .valid1_o     (valid1)
    );

    icache_data_ram u_data_ram (
        .clk         (clk),
        .index_i     (fetch_addr.fields.index),
        .fill_we_i   (fill_we),
        .fill_way_i  (fill_way),
        .fill_line_i (fill_line),
        .line0_o     (line0),
        .line1_o     (line1)
    );

    icache_replace u_replace (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .fetch_addr_i (fetch_addr),
        .valid0_i     (valid0),
        .valid1_i     (valid1),
        .touch_i      (touch),
        .touch_way_i  (touch_way),
        .fill_we_i    (fill_we),
        .fill_way_i   (fill_way),
        .victim_way_o (victim_way)
    );

    icache_refill u_refill (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fetch_addr_i   (fetch_addr),
        .refill_start_i (refill_start),
        .victim_way_i   (victim_way),
        .mem_req_o      (mem_req_o),
        .mem_addr_o     (mem_addr_o),
        .mem_rdata_i    (mem_rdata_i),
        .mem_valid_i    (mem_valid_i),
        .fill_we_o      (fill_we),
        .fill_way_o     (fill_way),
        .fill_line_o    (fill_line),
        .refill_done_o  (refill_done)
    );

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .fetch_addr_i   (fetch_addr),
        .fetch_req_i    (fetch_req_i),
        .core_stall_i   (core_stall_i),
        .tag0_i         (tag0),
        .tag1_i         (tag1),
        .valid0_i       (valid0),
        .valid1_i       (valid1),
        .line0_i        (line0),
        .line1_i        (line1),
        .refill_done_i  (refill_done),
        .refill_start_o (refill_start),
        .touch_o        (touch),
        .touch_way_o    (touch_way),
        .fetch_data_o   (fetch_data_o),
        .fetch_valid_o  (fetch_valid_o)
    );

endmodule

`default_nettype wire

/* list.f */
icache_pkg.sv
icache_tag_store.sv
icache_data_ram.sv
icache_replace.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

/* tb_icache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

    localparam logic [63:0] REGION_LO = 64'h1000_0000;
    localparam logic [63:0] REGION_HI = 64'h1000_0FFF;
    localparam int          WAIT_MAX  = 400;

    logic        clk          = 1'b0;
    logic        rst_n_i      = 1'b0;
    logic        fetch_req_i  = 1'b0;
    logic [63:0] fetch_addr_i = '0;
    logic        core_stall_i = 1'b0;
    logic        fence_i      = 1'b0;
    logic [63:0] mem_rdata_i  = '0;
    logic        mem_valid_i  = 1'b0;
    logic [31:0] fetch_data_o;
    logic        fetch_valid_o;
    logic        mem_req_o;
    logic [63:0] mem_addr_o;

    logic [31:0] stim_lfsr = 32'hf44c92dc;
    logic [31:0] mem_lfsr  = 32'hf44c92dc;
    logic [63:0] mem_log [$];
    logic [63:0] mem_addr_q;
    logic [2:0]  mem_wait;
    logic        mem_busy = 1'b0;
    logic [31:0] exp_word = '0;
    logic        pending  = 1'b0;
    int          errors   = 0;

    // reference tags, valid bits and ages per set
    logic [22:0] m_tag0 [64];
    logic [22:0] m_tag1 [64];
    bit          m_val0 [64];
    bit          m_val1 [64];
    int          m_age0 [64];
    int          m_age1 [64];

    always #5 clk = ~clk;

    icache_top UUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_req_i   (fetch_req_i),
        .fetch_addr_i  (fetch_addr_i),
        .core_stall_i  (core_stall_i),
        .fence_i       (fence_i),
        .fetch_data_o  (fetch_data_o),
        .fetch_valid_o (fetch_valid_o),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_rdata_i   (mem_rdata_i),
        .mem_valid_i   (mem_valid_i)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_next(state);
            v = {v[30:0], state[0]};
        end
    endtask

    // backing memory content for any 64-bit read
    function automatic logic [63:0] mem_word(input logic [63:0] a);
        return {a[31:0] ^ 32'h9e37_79b9, (a[31:0] * 32'h0001_0003) ^ 32'h7f4a_7c15};
    endfunction

    function automatic bit in_region(input logic [63:0] a);
        return (a >= REGION_LO) && (a <= REGION_HI);
    endfunction

    // word the core should see for a fetch address
    function automatic logic [31:0] expected_word(input logic [63:0] a);
        logic [63:0] base;
        logic [63:0] line;
        logic [63:0] hi_beat;
        logic [63:0] lo_beat;
        base = {a[63:3], 3'b000};
        if (in_region(a)) begin
            hi_beat = mem_word(base + 64'd4);
            lo_beat = mem_word(base);
            line = {hi_beat[31:0], lo_beat[31:0]};
        end else begin
            line = mem_word(base);
        end
        return a[2] ? line[63:32] : line[31:0];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "simulation stopped");
        end
    endtask

    // predicts hit or miss and applies the fill and the delivery
    task automatic model_fetch(input logic [63:0] addr, output logic hit);
        int          idx;
        logic [22:0] tag;
        logic        way;
        idx = addr[8:3];
        tag = addr[31:9];
        if (m_val0[idx] && m_tag0[idx] == tag) begin
            hit = 1'b1;
            way = 1'b0;
        end else if (m_val1[idx] && m_tag1[idx] == tag) begin
            hit = 1'b1;
            way = 1'b1;
        end else begin
            hit = 1'b0;
            if (!m_val0[idx]) way = 1'b0;
            else if (!m_val1[idx]) way = 1'b1;
            else way = (m_age0[idx] >= m_age1[idx]) ? 1'b0 : 1'b1;
            if (way) begin
                m_tag1[idx] = tag;
                m_val1[idx] = 1'b1;
            end else begin
                m_tag0[idx] = tag;
                m_val0[idx] = 1'b1;
            end
        end
        for (int s = 0; s < 64; s++) begin
            m_age0[s] = (m_age0[s] == 7) ? 7 : m_age0[s] + 1;
            m_age1[s] = (m_age1[s] == 7) ? 7 : m_age1[s] + 1;
        end
        if (way) m_age1[idx] = 0;
        else m_age0[idx] = 0;
    endtask

    task automatic do_fetch(input logic [63:0] addr, input int stall, output logic hit);
        logic [63:0] exp_addr [2];
        logic        model_hit;
        int          exp_n;
        int          cycles;
        bit          done;
        model_fetch(addr, model_hit);
        exp_n = 0;
        if (!model_hit && in_region(addr)) begin
            exp_addr[0] = {addr[63:3], 3'b100};
            exp_addr[1] = {addr[63:3], 3'b000};
            exp_n = 2;
        end else if (!model_hit) begin
            exp_addr[0] = {addr[63:3], 3'b000};
            exp_n = 1;
        end
        mem_log.delete();
        @(posedge clk);
        fetch_req_i  <= 1'b1;
        fetch_addr_i <= addr;
        core_stall_i <= (stall > 0);
        exp_word     <= expected_word(addr);
        pending      <= 1'b1;
        if (stall > 0) begin
            repeat (stall) @(posedge clk);
            core_stall_i <= 1'b0;
        end
        cycles = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            cycles++;
            if (fetch_valid_o) done = 1'b1;
            else if (cycles >= WAIT_MAX) abort_run("timeout: no fetch_valid_o for a fetch");
        end
        fetch_req_i <= 1'b0;
        pending     <= 1'b0;
        check_value("request count", mem_log.size(), exp_n);
        for (int i = 0; i < exp_n; i++) begin
            check_value("mem_addr_o", mem_log[i], exp_addr[i]);
        end
        // the DUT hit when it made no memory request
        hit = (mem_log.size() == 0);
        // a hit from idle is valid in the third cycle after the request is sampled
        if (model_hit && stall == 0) check_value("hit latency", cycles, 4);
    endtask

    // memory with a random answer delay
    always @(posedge clk) begin : memory_model
        logic [31:0] r;
        mem_valid_i <= 1'b0;
        if (!rst_n_i) begin
            mem_busy <= 1'b0;
        end else if (mem_busy) begin
            check_value("mem_req_o", mem_req_o, 1);
            check_value("mem_addr_o", mem_addr_o, mem_addr_q);
            if (mem_wait == 3'd0) begin
                mem_valid_i <= 1'b1;
                mem_rdata_i <= mem_word(mem_addr_q);
                mem_busy    <= 1'b0;
            end else begin
                mem_wait <= mem_wait - 3'd1;
            end
        end else if (mem_req_o) begin
            mem_log.push_back(mem_addr_o);
            draw_bits(mem_lfsr, 3, r);
            mem_addr_q <= mem_addr_o;
            mem_wait   <= r[2:0];
            mem_busy   <= 1'b1;
        end
    end

    always @(posedge clk) begin : fetch_checker
        if (rst_n_i && fetch_valid_o) begin
            if (!pending) abort_run("fetch_valid_o pulsed with no fetch pending");
            if (core_stall_i) abort_run("fetch_valid_o pulsed while the core stalls");
            check_value("fetch_data_o", fetch_data_o, exp_word);
        end
    end

    initial begin : stimulus
        logic        hit;
        logic [31:0] r;
        logic [63:0] addr;
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        @(posedge clk);
        check_value("fetch_valid_o", fetch_valid_o, 0);
        check_value("mem_req_o", mem_req_o, 0);

        // cold line and then its other word
        do_fetch(64'h0000_4104, 0, hit);
        check_value("cold fetch hit", hit, 0);
        do_fetch(64'h0000_4100, 0, hit);
        check_value("same line hit", hit, 1);

        // peripheral line takes two narrow beats
        do_fetch(64'h1000_0A54, 0, hit);
        check_value("peripheral hit", hit, 0);
        do_fetch(64'h1000_0A50, 0, hit);
        check_value("peripheral line hit", hit, 1);

        // in set 5 C evicts B once A has been used again
        do_fetch(64'h0001_0028, 0, hit);
        do_fetch(64'h0002_0028, 0, hit);
        do_fetch(64'h0001_0028, 0, hit);
        check_value("A again hit", hit, 1);
        do_fetch(64'h0003_0028, 0, hit);
        check_value("C hit", hit, 0);
        do_fetch(64'h0001_002C, 0, hit);
        check_value("A after C hit", hit, 1);
        do_fetch(64'h0002_0028, 0, hit);
        check_value("B after C hit", hit, 0);

        for (int i = 0; i < 24; i++) begin
            draw_bits(stim_lfsr, 4, r);
            addr = '0;
            addr[31:9] = 23'(r[1:0]) + 23'd1;
            addr[8:3] = r[2] ? 6'd6 : 6'd5;
            addr[2] = r[3];
            do_fetch(addr, 0, hit);
        end

        // fence sweeps every set
        @(posedge clk);
        fence_i <= 1'b1;
        repeat (70) @(posedge clk);
        fence_i <= 1'b0;
        for (int s = 0; s < 64; s++) begin
            m_val0[s] = 1'b0;
            m_val1[s] = 1'b0;
        end
        do_fetch(64'h0000_4104, 0, hit);
        check_value("after fence hit", hit, 0);
        do_fetch(64'h1000_0A54, 0, hit);
        check_value("after fence hit", hit, 0);
        do_fetch(64'h0001_0028, 0, hit);
        check_value("after fence hit", hit, 0);

        // core back-pressure on a hit and on a miss
        draw_bits(stim_lfsr, 4, r);
        do_fetch(64'h0000_4100, 5 + int'(r[3:0]), hit);
        check_value("stalled hit", hit, 1);
        draw_bits(stim_lfsr, 4, r);
        do_fetch(64'h0005_0030, 2 + int'(r[3:0]), hit);

        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
